//--- run.sh
#!/usr/bin/env bash
# Build and run the pin array testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module pin_array_tb \
  -f tb.f \
  -o sim_pin_array

out=$(./obj_dir/sim_pin_array) || true
echo "$out"
echo "$out" | grep -q "All tests passed"

//--- source/pin_array.sv
`timescale 1ns/1ns

// Bank of bus-controlled pin channels with a shared readback path.
module pin_array (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                enable,
  input  logic [pin_pkg::addr_width-1:0]      addr,
  input  logic                                data_wr,
  input  logic                                data_rd,
  input  logic [pin_pkg::data_width-1:0]      data_in,
  input  logic [pin_pkg::time_width-1:0]      current_time,
  input  logic                                output_sample,
  input  logic [7:0]                          channel_select,
  input  logic [pin_pkg::num_channels-1:0]    pin_in,
  output logic [pin_pkg::rd_width-1:0]        read_data,
  output logic                                read_valid,
  output logic [pin_pkg::sample_width-1:0]    sample_data,
  output logic                                sample_valid,
  output logic [pin_pkg::num_channels-1:0]    pin_out,
  output logic [pin_pkg::num_channels-1:0]    pin_oe
);

  logic [pin_pkg::rd_width-1:0]      chan_rd   [pin_pkg::num_channels];
  logic [pin_pkg::sample_width-1:0]  chan_word [pin_pkg::num_channels];
  logic [pin_pkg::num_channels-1:0]  chan_hit;

  pin_bus_if bus ();

  // Host side of the register bus.
  assign bus.enable  = enable;
  assign bus.addr    = addr;
  assign bus.data_wr = data_wr;
  assign bus.data_rd = data_rd;
  assign bus.data_in = data_in;

  for (genvar i = 0; i < pin_pkg::num_channels; i++) begin : g_chan
    pin_channel #(
      .position (i)
    ) u_channel (
      .clk            (clk),
      .reset          (reset),
      .bus            (bus.target),
      .current_time   (current_time),
      .output_sample  (output_sample),
      .channel_select (channel_select),
      .pin_in         (pin_in[i]),
      .rd_data        (chan_rd[i]),
      .sample_word    (chan_word[i]),
      .sample_hit     (chan_hit[i]),
      .pin_out        (pin_out[i]),
      .pin_oe         (pin_oe[i])
    );
  end

  readback_combine u_combine (
    .clk           (clk),
    .reset         (reset),
    .bus           (bus.target),
    .output_sample (output_sample),
    .rd_data_0     (chan_rd[0]),
    .rd_data_1     (chan_rd[1]),
    .sample_word_0 (chan_word[0]),
    .sample_word_1 (chan_word[1]),
    .sample_hit_0  (chan_hit[0]),
    .sample_hit_1  (chan_hit[1]),
    .read_data     (read_data),
    .read_valid    (read_valid),
    .sample_data   (sample_data),
    .sample_valid  (sample_valid)
  );

endmodule

//--- source/pin_bus_if.sv
`timescale 1ns/1ns

// Register bus shared by all channels and the readback combiner.
interface pin_bus_if;

  logic                            enable;
  logic [pin_pkg::addr_width-1:0]  addr;
  // Single-cycle write and read strobes.
  logic                            data_wr;
  logic                            data_rd;
  logic [pin_pkg::data_width-1:0]  data_in;

  // Driven by the top level.
  modport host (
    output enable, addr, data_wr, data_rd, data_in
  );

  // Seen by the channels and the combiner.
  modport target (
    input enable, addr, data_wr, data_rd, data_in
  );

endinterface

//--- source/pin_channel.sv
`timescale 1ns/1ns

// One pin channel: register block, command FSM, NCO and input sampler.
module pin_channel #(
  parameter int position = 0
) (
  input  logic                              clk,
  input  logic                              reset,
  pin_bus_if.target                         bus,
  input  logic [pin_pkg::time_width-1:0]    current_time,
  input  logic                              output_sample,
  input  logic [7:0]                        channel_select,
  input  logic                              pin_in,
  output logic [pin_pkg::rd_width-1:0]      rd_data,
  output logic [pin_pkg::sample_width-1:0]  sample_word,
  output logic                              sample_hit,
  output logic                              pin_out,
  output logic                              pin_oe
);

  logic                              chan_hit;
  logic [7:0]                        offset;
  logic                              wr_en;
  logic                              rd_en;
  logic                              sample_req;

  logic [31:0]                       nco_step;
  logic [pin_pkg::time_width-1:0]    end_time;
  logic [pin_pkg::cmd_width-1:0]     command;
  logic [pin_pkg::cmd_width-1:0]     cmd_seen;
  logic [31:0]                       sample_rate;
  logic [pin_pkg::rd_width-1:0]      last_data;

  pin_pkg::chan_state_t              state;
  pin_pkg::chan_state_t              state_next;
  logic                              cmd_accept;

  logic [31:0]                       rate_cnt;
  logic                              sample_bit;
  logic [pin_pkg::count_width-1:0]   sample_cnt;

  logic                              force_zero;
  logic                              force_one;
  logic                              pin_value;

  // Channel is selected by the upper address byte.
  assign chan_hit   = bus.enable && (bus.addr[15:8] == 8'(position));
  assign offset     = bus.addr[7:0];
  assign wr_en      = chan_hit && bus.data_wr;
  assign rd_en      = chan_hit && bus.data_rd;
  assign sample_req = output_sample && (channel_select == 8'(position));

  // Register writes. An accepted command clears the command register.
  always_ff @(posedge clk) begin
    if (reset) begin
      nco_step    <= '0;
      end_time    <= '0;
      command     <= '0;
      sample_rate <= '0;
      last_data   <= '0;
    end else begin
      if (wr_en) begin
        last_data <= bus.data_in[pin_pkg::rd_width-1:0];
        case (offset)
          pin_pkg::addr_nco_step:    nco_step    <= bus.data_in;
          pin_pkg::addr_end_time:    end_time    <= bus.data_in;
          pin_pkg::addr_command:     command     <= bus.data_in[pin_pkg::cmd_width-1:0];
          pin_pkg::addr_sample_rate: sample_rate <= bus.data_in;
          default: ;
        endcase
      end
      if (cmd_accept) begin
        command <= '0;
      end
    end
  end

  // Copy of the command as seen by the FSM, one cycle behind the register.
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_seen <= '0;
    end else if (cmd_accept) begin
      cmd_seen <= '0;
    end else begin
      cmd_seen <= command;
    end
  end

  // Command FSM next state.
  always_comb begin
    state_next = state;
    cmd_accept = 1'b0;
    case (state)
      pin_pkg::st_idle: begin
        case (cmd_seen)
          pin_pkg::cmd_start_output: begin
            state_next = pin_pkg::st_output;
            cmd_accept = 1'b1;
          end
          pin_pkg::cmd_const: begin
            state_next = pin_pkg::st_const;
            cmd_accept = 1'b1;
          end
          pin_pkg::cmd_input_stream: begin
            state_next = pin_pkg::st_stream;
            cmd_accept = 1'b1;
          end
          default: ;
        endcase
      end
      pin_pkg::st_output, pin_pkg::st_const: begin
        if (cmd_seen == pin_pkg::cmd_stop) begin
          state_next = pin_pkg::st_idle;
          cmd_accept = 1'b1;
        end else if (current_time >= end_time) begin
          state_next = pin_pkg::st_idle;
        end
      end
      pin_pkg::st_stream: begin
        // Streaming only ends on a stop command.
        if (cmd_seen == pin_pkg::cmd_stop) begin
          state_next = pin_pkg::st_idle;
          cmd_accept = 1'b1;
        end
      end
      default: state_next = pin_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= pin_pkg::st_idle;
      pin_oe <= 1'b0;
    end else begin
      state  <= state_next;
      pin_oe <= (state == pin_pkg::st_output) || (state == pin_pkg::st_const);
    end
  end

  // Phase held at zero unless driving, all ones in constant mode.
  assign force_zero = (state == pin_pkg::st_idle) || (state == pin_pkg::st_stream);
  assign force_one  = (state == pin_pkg::st_const);

  pin_nco u_nco (
    .clk        (clk),
    .reset      (reset),
    .step       (nco_step),
    .force_zero (force_zero),
    .force_one  (force_one),
    .pin_value  (pin_value)
  );

  assign pin_out = pin_oe && pin_value;

  // Sample-rate down-counter and sampler.
  always_ff @(posedge clk) begin
    if (reset) begin
      rate_cnt   <= '0;
      sample_bit <= 1'b0;
      sample_cnt <= '0;
    end else if (state == pin_pkg::st_stream) begin
      if (rate_cnt <= 32'd1) begin
        rate_cnt   <= sample_rate;
        sample_bit <= pin_in;
        sample_cnt <= sample_cnt + 1'b1;
      end else begin
        rate_cnt <= rate_cnt - 1'b1;
      end
    end else begin
      rate_cnt <= sample_rate;
      // New stream starts counting from zero.
      if (cmd_accept && (state_next == pin_pkg::st_stream)) begin
        sample_cnt <= '0;
      end
    end
  end

  // Registered read data and sample word, zero when not addressed.
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data     <= '0;
      sample_word <= '0;
      sample_hit  <= 1'b0;
    end else begin
      rd_data <= '0;
      if (rd_en) begin
        case (offset)
          pin_pkg::addr_sample_reg: rd_data <= {15'b0, sample_bit};
          pin_pkg::addr_sample_cnt: rd_data <= sample_cnt;
          pin_pkg::addr_status:     rd_data <= 16'(position);
          pin_pkg::addr_last_data:  rd_data <= last_data;
          default:                  rd_data <= '0;
        endcase
      end
      sample_hit <= sample_req;
      if (sample_req) begin
        sample_word <= {sample_cnt, 8'(position), 7'b0, sample_bit};
      end else begin
        sample_word <= '0;
      end
    end
  end

endmodule

//--- source/pin_nco.sv
`timescale 1ns/1ns

// Phase accumulator. The top phase bit is the pin value,
// so the output frequency is clk * step / 2^32.
module pin_nco (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] step,
  input  logic        force_zero,
  input  logic        force_one,
  output logic        pin_value
);

  logic [31:0] phase;
  logic [31:0] phase_next;

  // Forced modes override the accumulation.
  always_comb begin
    if (force_zero) begin
      phase_next = '0;
    end else if (force_one) begin
      phase_next = '1;
    end else begin
      phase_next = phase + step;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= '0;
    end else begin
      phase <= phase_next;
    end
  end

  // MSB of the phase.
  assign pin_value = phase[31];

endmodule

//--- source/pin_pkg.sv
package pin_pkg;

  // Bus and data widths.
  localparam int addr_width   = 19;
  localparam int data_width   = 32;
  localparam int rd_width     = 16;
  localparam int sample_width = 32;
  localparam int time_width   = 32;
  localparam int cmd_width    = 16;
  localparam int count_width  = 16;

  // Number of pin channels in the array.
  localparam int num_channels = 2;

  // Register offsets within a channel, low address byte.
  localparam logic [7:0] addr_nco_step    = 8'd1;
  localparam logic [7:0] addr_end_time    = 8'd2;
  localparam logic [7:0] addr_command     = 8'd3;
  localparam logic [7:0] addr_sample_rate = 8'd4;
  localparam logic [7:0] addr_sample_reg  = 8'd5;
  localparam logic [7:0] addr_sample_cnt  = 8'd7;
  localparam logic [7:0] addr_status      = 8'd8;
  localparam logic [7:0] addr_last_data   = 8'd9;

  // Command codes written to addr_command.
  localparam logic [cmd_width-1:0] cmd_start_output = 16'd1;
  localparam logic [cmd_width-1:0] cmd_const        = 16'd2;
  localparam logic [cmd_width-1:0] cmd_input_stream = 16'd3;
  localparam logic [cmd_width-1:0] cmd_stop         = 16'd5;

  // One-hot channel states.
  typedef enum logic [3:0] {
    st_idle   = 4'b0001,
    st_output = 4'b0010,
    st_const  = 4'b0100,
    st_stream = 4'b1000
  } chan_state_t;

endpackage

//--- source/readback_combine.sv
`timescale 1ns/1ns

// Merges channel read data and sample words into registered bus results.
module readback_combine (
  input  logic                              clk,
  input  logic                              reset,
  pin_bus_if.target                         bus,
  input  logic                              output_sample,
  input  logic [pin_pkg::rd_width-1:0]      rd_data_0,
  input  logic [pin_pkg::rd_width-1:0]      rd_data_1,
  input  logic [pin_pkg::sample_width-1:0]  sample_word_0,
  input  logic [pin_pkg::sample_width-1:0]  sample_word_1,
  input  logic                              sample_hit_0,
  input  logic                              sample_hit_1,
  output logic [pin_pkg::rd_width-1:0]      read_data,
  output logic                              read_valid,
  output logic [pin_pkg::sample_width-1:0]  sample_data,
  output logic                              sample_valid
);

  logic [pin_pkg::rd_width-1:0]      rd_all   [pin_pkg::num_channels];
  logic [pin_pkg::sample_width-1:0]  word_all [pin_pkg::num_channels];
  logic [pin_pkg::num_channels-1:0]  hit_all;
  logic [pin_pkg::rd_width-1:0]      rd_merged;
  logic [pin_pkg::sample_width-1:0]  word_sel;
  logic                              data_rd_d;
  logic                              output_sample_d;

  assign rd_all[0]   = rd_data_0;
  assign rd_all[1]   = rd_data_1;
  assign word_all[0] = sample_word_0;
  assign word_all[1] = sample_word_1;
  assign hit_all     = {sample_hit_1, sample_hit_0};

  // Unaddressed channels return zero, so an OR merges the reads.
  always_comb begin
    rd_merged = '0;
    word_sel  = '0;
    for (int i = 0; i < pin_pkg::num_channels; i++) begin
      rd_merged = rd_merged | rd_all[i];
      if (hit_all[i]) begin
        word_sel = word_all[i];
      end
    end
  end

  // Strobes delayed to line up with the channels' registered outputs.
  always_ff @(posedge clk) begin
    if (reset) begin
      data_rd_d       <= 1'b0;
      output_sample_d <= 1'b0;
      read_data       <= '0;
      read_valid      <= 1'b0;
      sample_data     <= '0;
      sample_valid    <= 1'b0;
    end else begin
      data_rd_d       <= bus.data_rd;
      output_sample_d <= output_sample;
      read_data       <= rd_merged;
      read_valid      <= data_rd_d;
      sample_data     <= word_sel;
      sample_valid    <= output_sample_d && (|hit_all);
    end
  end

endmodule

//--- tb.f
source/pin_pkg.sv
source/pin_bus_if.sv
source/pin_nco.sv
source/pin_channel.sv
source/readback_combine.sv
source/pin_array.sv
tests/pin_array_props.sv
tests/pin_array_tb.sv

//--- tests/pin_array_props.sv
`timescale 1ns/1ns

// Channel FSM properties, bound into every pin_channel.
module pin_array_props (
  input logic                           clk,
  input logic                           reset,
  input pin_pkg::chan_state_t           state,
  input logic                           pin_oe,
  input logic                           cmd_accept,
  input logic [pin_pkg::cmd_width-1:0]  command
);

  logic quiet_now;

  assign quiet_now = (state == pin_pkg::st_idle) || (state == pin_pkg::st_stream);

  // pin_oe follows the state one cycle late.
  a_oe_low: assert property (@(posedge clk) disable iff (reset)
    quiet_now && $past(quiet_now) |-> !pin_oe)
    else $error("pin_oe high while channel is idle or streaming");

  a_one_hot: assert property (@(posedge clk) disable iff (reset)
    $onehot(state))
    else $error("channel state is not one-hot");

  a_cmd_clear: assert property (@(posedge clk) disable iff (reset)
    cmd_accept |=> (command == '0))
    else $error("command register not cleared after accept");

endmodule

bind pin_channel pin_array_props u_props (
  .clk        (clk),
  .reset      (reset),
  .state      (state),
  .pin_oe     (pin_oe),
  .cmd_accept (cmd_accept),
  .command    (command)
);

//--- tests/pin_array_tb.sv
`timescale 1ns/1ns

module pin_array_tb;

  typedef enum logic [3:0] {
    op_write, op_read, op_sample, op_wait, op_pin, op_time, op_trace
  } op_t;

  typedef struct packed {
    logic [3:0]  test;
    op_t         op;
    logic [18:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
  } entry_t;

  logic        clk;
  logic        reset;
  logic        enable;
  logic [18:0] addr;
  logic        data_wr;
  logic        data_rd;
  logic [31:0] data_in;
  logic [31:0] current_time;
  logic        output_sample;
  logic [7:0]  channel_select;
  logic [1:0]  pin_in;
  logic [15:0] read_data;
  logic        read_valid;
  logic [31:0] sample_data;
  logic        sample_valid;
  logic [1:0]  pin_out;
  logic [1:0]  pin_oe;

  entry_t      table_q[$];
  logic [31:0] lfsr;
  // Pin value seen by the DUT at each edge.
  logic [1:0]  pin_hist [8192];
  int          cyc;
  int          stream_start [2];
  int          stream_stop [2];
  logic [31:0] stream_rate [2];
  int          checks;
  int          errors;

  pin_array DUT (
    .clk(clk), .reset(reset), .enable(enable), .addr(addr),
    .data_wr(data_wr), .data_rd(data_rd), .data_in(data_in),
    .current_time(current_time), .output_sample(output_sample),
    .channel_select(channel_select), .pin_in(pin_in),
    .read_data(read_data), .read_valid(read_valid),
    .sample_data(sample_data), .sample_valid(sample_valid),
    .pin_out(pin_out), .pin_oe(pin_oe)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] x);
    return x[0] ? ((x >> 1) ^ 32'h80200003) : (x >> 1);
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1: return "register readback";
      2: return "constant mode";
      3: return "nco output";
      4: return "input stream";
      5: return "stop command";
      default: return "channel isolation";
    endcase
  endfunction

  task automatic add_entry(input int t, input op_t op, input int ch, input int off,
                           input int d, input int x);
    entry_t e;
    e.test = 4'(t);
    e.op   = op;
    e.addr = {3'b000, 8'(ch), 8'(off)};
    e.data = d;
    e.exp  = x;
    table_q.push_back(e);
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t ns: %s actual %h expected %h", $time, name, actual,
               expected);
    end
  endtask

  // Advance one clock and drive inputs 2 ns after the edge.
  task automatic step();
    @(posedge clk);
    #2;
    cyc = cyc + 1;
    current_time = current_time + 32'd1;
    lfsr = lfsr_next(lfsr);
    pin_in[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    pin_in[1] = lfsr[0];
    pin_hist[cyc + 1] = pin_in;
  endtask

  task automatic bus_write(input logic [18:0] a, input logic [31:0] d);
    int ch;
    ch = int'(a[15:8]);
    enable  = 1'b1;
    addr    = a;
    data_in = d;
    data_wr = 1'b1;
    step();
    data_wr = 1'b0;
    enable  = 1'b0;
    if (ch < 2) begin
      if (a[7:0] == pin_pkg::addr_sample_rate) stream_rate[ch] = d;
      if (a[7:0] == pin_pkg::addr_command && d[15:0] == pin_pkg::cmd_input_stream) begin
        stream_start[ch] = cyc;
        stream_stop[ch]  = -1;
      end
      if (a[7:0] == pin_pkg::addr_command && d[15:0] == pin_pkg::cmd_stop) begin
        stream_stop[ch] = cyc;
      end
    end
  endtask

  task automatic bus_read(input logic [18:0] a, input logic [31:0] x);
    int waited;
    enable  = 1'b1;
    addr    = a;
    data_rd = 1'b1;
    step();
    data_rd = 1'b0;
    enable  = 1'b0;
    waited  = 0;
    while (read_valid !== 1'b1 && waited < 8) begin
      step();
      waited++;
    end
    if (read_valid !== 1'b1) begin
      errors++;
      $display("read of address %h never raised read_valid", a);
    end else begin
      check("read_valid delay", waited, 1);
      check("read_data", 32'(read_data), x);
    end
  endtask

  // Expected word counts one sample per period of max(rate, 1) cycles.
  task automatic sample_check(input logic [7:0] sel);
    int ch;
    int s;
    int last;
    int k;
    int r;
    int waited;
    logic bit_v;
    logic [31:0] want;
    ch = int'(sel);
    output_sample  = 1'b1;
    channel_select = sel;
    step();
    s = cyc;
    output_sample = 1'b0;
    waited = 0;
    while (sample_valid !== 1'b1 && waited < 6) begin
      step();
      waited++;
    end
    if (ch >= 2) begin
      checks++;
      if (sample_valid === 1'b1) begin
        errors++;
        $display("sample request for channel %0d raised sample_valid", ch);
      end
    end else if (sample_valid !== 1'b1) begin
      errors++;
      $display("sample request for channel %0d never raised sample_valid", ch);
    end else begin
      r = (stream_rate[ch] == 32'd0) ? 1 : int'(stream_rate[ch]);
      last = s - 1;
      if (stream_stop[ch] >= 0 && stream_stop[ch] + 2 < last) last = stream_stop[ch] + 2;
      k = 0;
      if (stream_start[ch] >= 0 && last >= stream_start[ch] + 2) begin
        k = (last - stream_start[ch] - 2) / r;
      end
      bit_v = (k > 0) ? pin_hist[stream_start[ch] + 2 + k * r][ch] : 1'b0;
      want = {16'(k), 8'(ch), 7'b0, bit_v};
      check("sample_valid delay", waited, 1);
      check("sample_data", sample_data, want);
    end
  endtask

  task automatic pin_check(input int ch, input logic [1:0] want);
    check("pin_oe", 32'(pin_oe[ch]), 32'(want[1]));
    check("pin_out", 32'(pin_out[ch]), 32'(want[0]));
  endtask

  // Phase starts at one step on the first driven cycle.
  task automatic pin_trace(input int ch, input logic [31:0] stp, input int n);
    logic [31:0] phase;
    phase = stp;
    for (int i = 0; i < n; i++) begin
      check("pin_oe", 32'(pin_oe[ch]), 32'd1);
      check("pin_out", 32'(pin_out[ch]), 32'(phase[31]));
      step();
      phase = phase + stp;
    end
  endtask

  task automatic build_table();
    add_entry(1, op_write, 0, 'h20, 32'h0000_1234, 0);
    add_entry(1, op_write, 1, 'h21, 32'habcd_5678, 0);
    add_entry(1, op_read, 0, 9, 0, 32'h1234);
    add_entry(1, op_read, 1, 9, 0, 32'h5678);
    add_entry(1, op_read, 0, 8, 0, 0);
    add_entry(1, op_read, 1, 8, 0, 1);
    add_entry(1, op_read, 0, 6, 0, 0);
    add_entry(2, op_time, 0, 0, 0, 0);
    add_entry(2, op_write, 0, 2, 40, 0);
    add_entry(2, op_write, 0, 3, 2, 0);
    add_entry(2, op_wait, 0, 0, 2, 0);
    add_entry(2, op_pin, 0, 0, 0, 0);
    add_entry(2, op_wait, 0, 0, 1, 0);
    add_entry(2, op_pin, 0, 0, 0, 3);
    add_entry(2, op_wait, 0, 0, 20, 0);
    add_entry(2, op_pin, 0, 0, 0, 3);
    add_entry(2, op_wait, 0, 0, 16, 0);
    add_entry(2, op_pin, 0, 0, 0, 3);
    add_entry(2, op_wait, 0, 0, 1, 0);
    add_entry(2, op_pin, 0, 0, 0, 0);
    add_entry(3, op_write, 0, 2, 32'hffff_ffff, 0);
    add_entry(3, op_write, 0, 1, 32'h8000_0000, 0);
    add_entry(3, op_write, 0, 3, 1, 0);
    add_entry(3, op_wait, 0, 0, 3, 0);
    add_entry(3, op_trace, 0, 0, 32'h8000_0000, 8);
    add_entry(3, op_write, 0, 3, 5, 0);
    add_entry(3, op_wait, 0, 0, 3, 0);
    add_entry(3, op_pin, 0, 0, 0, 0);
    add_entry(3, op_write, 0, 1, 32'h4000_0000, 0);
    add_entry(3, op_write, 0, 3, 1, 0);
    add_entry(3, op_wait, 0, 0, 3, 0);
    add_entry(3, op_trace, 0, 0, 32'h4000_0000, 12);
    add_entry(3, op_write, 0, 3, 5, 0);
    add_entry(3, op_wait, 0, 0, 3, 0);
    add_entry(3, op_pin, 0, 0, 0, 0);
    add_entry(4, op_write, 1, 4, 3, 0);
    add_entry(4, op_write, 1, 3, 3, 0);
    add_entry(4, op_wait, 0, 0, 4, 0);
    add_entry(4, op_pin, 1, 0, 0, 0);
    add_entry(4, op_wait, 0, 0, 6, 0);
    add_entry(4, op_sample, 1, 0, 0, 0);
    add_entry(4, op_wait, 0, 0, 5, 0);
    add_entry(4, op_sample, 1, 0, 0, 0);
    add_entry(5, op_write, 1, 3, 5, 0);
    add_entry(5, op_wait, 0, 0, 3, 0);
    add_entry(5, op_pin, 1, 0, 0, 0);
    add_entry(5, op_wait, 0, 0, 7, 0);
    add_entry(5, op_sample, 1, 0, 0, 0);
    add_entry(5, op_wait, 0, 0, 4, 0);
    add_entry(5, op_sample, 1, 0, 0, 0);
    add_entry(6, op_write, 1, 1, 32'h8000_0000, 0);
    add_entry(6, op_write, 1, 'h30, 32'h0000_9999, 0);
    add_entry(6, op_read, 0, 9, 0, 5);
    add_entry(6, op_read, 1, 9, 0, 32'h9999);
    add_entry(6, op_write, 1, 2, 32'hffff_ffff, 0);
    add_entry(6, op_write, 1, 3, 1, 0);
    add_entry(6, op_wait, 0, 0, 3, 0);
    add_entry(6, op_trace, 1, 0, 32'h8000_0000, 4);
    add_entry(6, op_pin, 0, 0, 0, 0);
    add_entry(6, op_sample, 5, 0, 0, 0);
    add_entry(6, op_sample, 0, 0, 0, 0);
  endtask

  // Watchdog sized from the table length.
  initial begin
    #1;
    #(table_q.size() * 64 * 40);
    $display("Timeout: the test table did not finish in time");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    entry_t e;
    int cur_test;
    int base_errors;
    reset = 1'b1;
    enable = 1'b0;
    addr = '0;
    data_wr = 1'b0;
    data_rd = 1'b0;
    data_in = '0;
    current_time = '0;
    output_sample = 1'b0;
    channel_select = '0;
    pin_in = '0;
    lfsr = 32'h4ebc0140;
    cyc = 0;
    checks = 0;
    errors = 0;
    for (int c = 0; c < 2; c++) begin
      stream_start[c] = -1;
      stream_stop[c]  = -1;
      stream_rate[c]  = '0;
    end
    build_table();
    repeat (4) step();
    reset = 1'b0;
    cur_test = int'(table_q[0].test);
    base_errors = 0;
    for (int i = 0; i < table_q.size(); i++) begin
      e = table_q[i];
      if (int'(e.test) != cur_test) begin
        $display("test %0d %s: %s", cur_test, test_name(cur_test),
                 (errors == base_errors) ? "ok" : "failed");
        cur_test = int'(e.test);
        base_errors = errors;
      end
      case (e.op)
        op_write:  bus_write(e.addr, e.data);
        op_read:   bus_read(e.addr, e.exp);
        op_sample: sample_check(e.addr[15:8]);
        op_wait:   repeat (e.data) step();
        op_pin:    pin_check(int'(e.addr[15:8]), e.exp[1:0]);
        op_time:   current_time = e.data;
        default:   pin_trace(int'(e.addr[15:8]), e.data, int'(e.exp));
      endcase
    end
    $display("test %0d %s: %s", cur_test, test_name(cur_test),
             (errors == base_errors) ? "ok" : "failed");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
